// ==== hdl/agu_pkg.sv ====
package agu_pkg;

    // word address width for source and destination
    localparam int agu_addr_w = 13;

    // nested loop depth, level 3 innermost
    localparam int agu_lvl_n = 4;

    // wishbone data width on both ports
    localparam int agu_data_w = 32;

    // slave register index width
    localparam int agu_reg_adr_w = 4;

    // slave register map
    typedef enum logic [agu_reg_adr_w-1:0] {
        reg_ctrl     = 4'd0,
        reg_status   = 4'd1,
        reg_src_base = 4'd2,
        reg_dst_base = 4'd3,
        reg_gap0     = 4'd4,
        reg_gap1     = 4'd5,
        reg_gap2     = 4'd6,
        reg_gap3     = 4'd7,
        reg_len0     = 4'd8,
        reg_len1     = 4'd9,
        reg_len2     = 4'd10,
        reg_len3     = 4'd11
    } agu_reg_e;

    // transfer controller states
    typedef enum logic [1:0] {
        st_idle,
        st_load,
        st_read,
        st_write
    } dma_state_e;

endpackage

// ==== hdl/agu_addr_gen.sv ====
`timescale 1ns/100ps

module agu_addr_gen import agu_pkg::*; (
    input  logic                                  clk,
    input  logic                                  rst_n,

    input  logic [agu_addr_w-1:0]                 cfg_base_addr,
    input  logic [agu_lvl_n-1:0][agu_addr_w-1:0]  cfg_gap,
    input  logic [agu_lvl_n-1:0][agu_addr_w-1:0]  cfg_len,

    input  logic                                  init_en,
    input  logic                                  step,

    output logic [agu_addr_w-1:0]                 addr,
    output logic                                  last
);

    // run configuration, captured on init
    logic [agu_addr_w-1:0]                base_q;
    logic [agu_lvl_n-1:0][agu_addr_w-1:0] gap_q;
    logic [agu_lvl_n-1:0][agu_addr_w-1:0] len_q;

    // per level loop state
    logic [agu_lvl_n-1:0][agu_addr_w-1:0] loop_cnt;
    logic [agu_lvl_n-1:0][agu_addr_w-1:0] loop_cnt_ns;
    logic [agu_lvl_n-1:0][agu_addr_w-1:0] loop_part;
    logic [agu_lvl_n-1:0][agu_addr_w-1:0] loop_part_ns;

    logic [agu_lvl_n-1:0] lvl_hit;
    logic [agu_lvl_n-1:0] lvl_adv;
    logic [agu_addr_w-1:0] base_sel;
    logic [agu_addr_w-1:0] addr_ns;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            base_q <= '0;
            gap_q  <= '0;
            len_q  <= '0;
        end else if (init_en) begin
            base_q <= cfg_base_addr;
            gap_q  <= cfg_gap;
            len_q  <= cfg_len;
        end
    end

    // a level has reached its length
    always_comb begin
        for (int k = 0; k < agu_lvl_n; k++) begin
            lvl_hit[k] = (loop_cnt[k] == len_q[k]);
        end
    end

    // innermost always moves on step, outer ones carry in
    always_comb begin
        lvl_adv[agu_lvl_n-1] = step;
        for (int k = agu_lvl_n - 2; k >= 0; k--) begin
            lvl_adv[k] = lvl_adv[k+1] & lvl_hit[k+1];
        end
    end

    always_comb begin
        for (int k = 0; k < agu_lvl_n; k++) begin
            loop_cnt_ns[k]  = loop_cnt[k];
            loop_part_ns[k] = loop_part[k];

            if (init_en) begin
                loop_cnt_ns[k]  = '0;
                loop_part_ns[k] = '0;
            end else if (lvl_adv[k]) begin
                if (lvl_hit[k]) begin
                    // wrap this level back to its first element
                    loop_cnt_ns[k]  = '0;
                    loop_part_ns[k] = '0;
                end else begin
                    loop_cnt_ns[k]  = loop_cnt[k] + agu_addr_w'(1);
                    loop_part_ns[k] = loop_part[k] + gap_q[k];
                end
            end
        end
    end

    // first address is the new base itself
    assign base_sel = init_en ? cfg_base_addr : base_q;

    // sum wraps modulo the address space
    always_comb begin
        addr_ns = base_sel;
        for (int k = 0; k < agu_lvl_n; k++) begin
            addr_ns = addr_ns + loop_part_ns[k];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            loop_cnt  <= '0;
            loop_part <= '0;
        end else begin
            loop_cnt  <= loop_cnt_ns;
            loop_part <= loop_part_ns;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr <= '0;
        end else if (init_en || step) begin
            addr <= addr_ns;
        end
    end

    // final element once every level sits at its length
    assign last = &lvl_hit;

endmodule

// ==== hdl/agu_cfg_regs.sv ====
`timescale 1ns/100ps

module agu_cfg_regs import agu_pkg::*; (
    input  logic                                  clk,
    input  logic                                  rst_n,

    // wishbone classic slave
    input  logic                                  s_cyc,
    input  logic                                  s_stb,
    input  logic                                  s_we,
    input  logic [agu_reg_adr_w-1:0]              s_adr,
    input  logic [agu_data_w-1:0]                 s_dat_w,
    output logic [agu_data_w-1:0]                 s_dat_r,
    output logic                                  s_ack,

    input  logic                                  busy,
    output logic                                  start,

    output logic [agu_addr_w-1:0]                 cfg_src_base,
    output logic [agu_addr_w-1:0]                 cfg_dst_base,
    output logic [agu_lvl_n-1:0][agu_addr_w-1:0]  cfg_gap,
    output logic [agu_lvl_n-1:0][agu_addr_w-1:0]  cfg_len
);

    logic                  req;
    logic                  wr_en;
    logic                  busy_q;
    logic                  done;
    logic [agu_data_w-1:0] rd_data;

    // new request, not yet acknowledged
    assign req   = s_cyc & s_stb & ~s_ack;
    assign wr_en = req & s_we;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_ack <= 1'b0;
        end else begin
            s_ack <= req;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start <= 1'b0;
        end else begin
            start <= wr_en && (agu_reg_e'(s_adr) == reg_ctrl) && s_dat_w[0];
        end
    end

    // gap and len indices share their low two bits with the level
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_src_base <= '0;
            cfg_dst_base <= '0;
            cfg_gap      <= '0;
            cfg_len      <= '0;
        end else if (wr_en) begin
            case (agu_reg_e'(s_adr))
                reg_src_base: cfg_src_base <= s_dat_w[agu_addr_w-1:0];
                reg_dst_base: cfg_dst_base <= s_dat_w[agu_addr_w-1:0];
                reg_gap0, reg_gap1, reg_gap2, reg_gap3:
                    cfg_gap[s_adr[1:0]] <= s_dat_w[agu_addr_w-1:0];
                reg_len0, reg_len1, reg_len2, reg_len3:
                    cfg_len[s_adr[1:0]] <= s_dat_w[agu_addr_w-1:0];
                default: ;
            endcase
        end
    end

    // sticky done, set when busy falls
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            done   <= 1'b0;
        end else begin
            busy_q <= busy;
            if (start) begin
                done <= 1'b0;
            end else if (busy_q && !busy) begin
                done <= 1'b1;
            end
        end
    end

    always_comb begin
        rd_data = '0;
        case (agu_reg_e'(s_adr))
            reg_status:   rd_data[1:0] = {done, busy};
            reg_src_base: rd_data[agu_addr_w-1:0] = cfg_src_base;
            reg_dst_base: rd_data[agu_addr_w-1:0] = cfg_dst_base;
            reg_gap0, reg_gap1, reg_gap2, reg_gap3:
                rd_data[agu_addr_w-1:0] = cfg_gap[s_adr[1:0]];
            reg_len0, reg_len1, reg_len2, reg_len3:
                rd_data[agu_addr_w-1:0] = cfg_len[s_adr[1:0]];
            // ctrl and unmapped read as zero
            default: rd_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_dat_r <= '0;
        end else if (req) begin
            s_dat_r <= rd_data;
        end
    end

endmodule

// ==== hdl/agu_dma_ctrl.sv ====
`timescale 1ns/100ps

module agu_dma_ctrl import agu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,

    input  logic                   start,
    output logic                   busy,
    input  logic [agu_addr_w-1:0]  cfg_dst_base,

    // address generator handshake
    output logic                   gen_init,
    output logic                   gen_step,
    input  logic [agu_addr_w-1:0]  gen_addr,
    input  logic                   gen_last,

    // wishbone classic master
    output logic                   m_cyc,
    output logic                   m_stb,
    output logic                   m_we,
    output logic [agu_addr_w-1:0]  m_adr,
    output logic [agu_data_w-1:0]  m_dat_w,
    input  logic [agu_data_w-1:0]  m_dat_r,
    input  logic                   m_ack
);

    dma_state_e state_q;
    dma_state_e state_d;

    logic [agu_addr_w-1:0] dst_base_q;
    logic [agu_addr_w-1:0] dst_idx;
    logic [agu_addr_w-1:0] dst_addr;
    logic [agu_data_w-1:0] data_q;
    logic                  wr_done;

    assign wr_done = (state_q == st_write) && m_ack;

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (start) begin
                    state_d = st_load;
                end
            end
            st_load: state_d = st_read;
            st_read: begin
                if (m_ack) begin
                    state_d = st_write;
                end
            end
            st_write: begin
                if (m_ack) begin
                    state_d = gen_last ? st_idle : st_read;
                end
            end
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // destination walks linearly from the latched base
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dst_base_q <= '0;
            dst_idx    <= '0;
        end else if (state_q == st_load) begin
            dst_base_q <= cfg_dst_base;
            dst_idx    <= '0;
        end else if (wr_done) begin
            dst_idx <= dst_idx + agu_addr_w'(1);
        end
    end

    assign dst_addr = dst_base_q + dst_idx;

    // read word held until its write completes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_q <= '0;
        end else if ((state_q == st_read) && m_ack) begin
            data_q <= m_dat_r;
        end
    end

    assign busy     = (state_q != st_idle);
    assign gen_init = (state_q == st_load);

    // no step after the final element
    assign gen_step = wr_done && !gen_last;

    // one transfer per state, fields stable until ack
    assign m_cyc   = (state_q == st_read) || (state_q == st_write);
    assign m_stb   = m_cyc;
    assign m_we    = (state_q == st_write);
    assign m_adr   = m_we ? dst_addr : gen_addr;
    assign m_dat_w = data_q;

endmodule

// ==== hdl/agu_top.sv ====
`timescale 1ns/100ps

module agu_top import agu_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,

    // host register port
    input  logic                      s_cyc,
    input  logic                      s_stb,
    input  logic                      s_we,
    input  logic [agu_reg_adr_w-1:0]  s_adr,
    input  logic [agu_data_w-1:0]     s_dat_w,
    output logic [agu_data_w-1:0]     s_dat_r,
    output logic                      s_ack,

    // scratchpad memory port
    output logic                      m_cyc,
    output logic                      m_stb,
    output logic                      m_we,
    output logic [agu_addr_w-1:0]     m_adr,
    output logic [agu_data_w-1:0]     m_dat_w,
    input  logic [agu_data_w-1:0]     m_dat_r,
    input  logic                      m_ack
);

    logic                                 start;
    logic                                 busy;
    logic [agu_addr_w-1:0]                cfg_src_base;
    logic [agu_addr_w-1:0]                cfg_dst_base;
    logic [agu_lvl_n-1:0][agu_addr_w-1:0] cfg_gap;
    logic [agu_lvl_n-1:0][agu_addr_w-1:0] cfg_len;
    logic                                 gen_init;
    logic                                 gen_step;
    logic [agu_addr_w-1:0]                gen_addr;
    logic                                 gen_last;

    agu_cfg_regs regs_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .s_cyc        (s_cyc),
        .s_stb        (s_stb),
        .s_we         (s_we),
        .s_adr        (s_adr),
        .s_dat_w      (s_dat_w),
        .s_dat_r      (s_dat_r),
        .s_ack        (s_ack),
        .busy         (busy),
        .start        (start),
        .cfg_src_base (cfg_src_base),
        .cfg_dst_base (cfg_dst_base),
        .cfg_gap      (cfg_gap),
        .cfg_len      (cfg_len)
    );

    agu_dma_ctrl ctrl_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .busy         (busy),
        .cfg_dst_base (cfg_dst_base),
        .gen_init     (gen_init),
        .gen_step     (gen_step),
        .gen_addr     (gen_addr),
        .gen_last     (gen_last),
        .m_cyc        (m_cyc),
        .m_stb        (m_stb),
        .m_we         (m_we),
        .m_adr        (m_adr),
        .m_dat_w      (m_dat_w),
        .m_dat_r      (m_dat_r),
        .m_ack        (m_ack)
    );

    agu_addr_gen gen_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_base_addr (cfg_src_base),
        .cfg_gap       (cfg_gap),
        .cfg_len       (cfg_len),
        .init_en       (gen_init),
        .step          (gen_step),
        .addr          (gen_addr),
        .last          (gen_last)
    );

endmodule

// ==== tb/tb_agu_top.sv ====
`timescale 1ns/100ps

module tb_agu_top import agu_pkg::*; ();

    localparam int n_runs         = 10;
    localparam int max_elems      = 256;
    localparam int timeout_cycles = n_runs * max_elems * 2 * 6 + 2000;
    localparam int mem_words      = 1 << agu_addr_w;

    logic                     clk;
    logic                     rst_n;
    logic                     s_cyc;
    logic                     s_stb;
    logic                     s_we;
    logic [agu_reg_adr_w-1:0] s_adr;
    logic [agu_data_w-1:0]    s_dat_w;
    logic [agu_data_w-1:0]    s_dat_r;
    logic                     s_ack;
    logic                     m_cyc;
    logic                     m_stb;
    logic                     m_we;
    logic [agu_addr_w-1:0]    m_adr;
    logic [agu_data_w-1:0]    m_dat_w;
    logic [agu_data_w-1:0]    m_dat_r;
    logic                     m_ack;

    // scratchpad model and its expected image
    logic [agu_data_w-1:0] mem [0:mem_words-1];
    logic [agu_data_w-1:0] exp_mem [0:mem_words-1];
    logic [agu_addr_w-1:0] rd_q[$];
    logic [agu_addr_w-1:0] exp_rd_q[$];

    // current run configuration
    logic [31:0]           wr_val [0:15];
    logic [agu_addr_w-1:0] run_src;
    logic [agu_addr_w-1:0] run_dst;
    logic [agu_addr_w-1:0] run_gap [0:agu_lvl_n-1];
    logic [agu_addr_w-1:0] run_len [0:agu_lvl_n-1];

    // memory responder state
    logic                  pending;
    logic                  hold_chk;
    int                    wait_cnt;
    logic [agu_addr_w-1:0] held_adr;
    logic                  held_we;
    logic [agu_data_w-1:0] held_dat;
    logic [31:0]           bp_rnd;

    integer seed = 89021;
    int     wr_cnt = 0;
    int     checks = 0;
    int     errors = 0;
    int     cycle_cnt = 0;

    agu_top agu_top_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .s_cyc   (s_cyc),
        .s_stb   (s_stb),
        .s_we    (s_we),
        .s_adr   (s_adr),
        .s_dat_w (s_dat_w),
        .s_dat_r (s_dat_r),
        .s_ack   (s_ack),
        .m_cyc   (m_cyc),
        .m_stb   (m_stb),
        .m_we    (m_we),
        .m_adr   (m_adr),
        .m_dat_w (m_dat_w),
        .m_dat_r (m_dat_r),
        .m_ack   (m_ack)
    );

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    task automatic check_eq(input string name, input logic [31:0] exp_val,
                            input logic [31:0] act_val);
        checks++;
        assert (act_val === exp_val) else begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp_val, act_val);
        end
    endtask

    task automatic report_totals();
        $display("checks %0d, errors %0d", checks, errors);
    endtask

    // wishbone classic host cycles entered and left on a falling edge
    task automatic host_write(input logic [agu_reg_adr_w-1:0] adr, input logic [31:0] data);
        s_cyc   = 1'b1;
        s_stb   = 1'b1;
        s_we    = 1'b1;
        s_adr   = adr;
        s_dat_w = data;
        @(negedge clk);
        while (!s_ack) begin
            @(negedge clk);
        end
        s_cyc = 1'b0;
        s_stb = 1'b0;
        s_we  = 1'b0;
    endtask

    task automatic host_read(input logic [agu_reg_adr_w-1:0] adr, output logic [31:0] data);
        s_cyc = 1'b1;
        s_stb = 1'b1;
        s_we  = 1'b0;
        s_adr = adr;
        @(negedge clk);
        while (!s_ack) begin
            @(negedge clk);
        end
        data  = s_dat_r;
        s_cyc = 1'b0;
        s_stb = 1'b0;
    endtask

    task automatic configure_run(input int run);
        logic [31:0] rnd;
        logic [31:0] rd;
        wr_val[reg_src_base] = $random(seed);
        wr_val[reg_dst_base] = $random(seed);
        for (int k = 0; k < agu_lvl_n; k++) begin
            rnd = $random(seed);
            // large gaps on run 1 so the address sum wraps
            if (run == 1) begin
                rnd[12:8] = 5'h1f;
            end
            wr_val[reg_gap0 + k] = rnd;
            rnd = $random(seed);
            // upper junk bits must be dropped by the register
            rnd[12:2] = '0;
            if (run == 0) begin
                rnd[1:0] = 2'd0;
            end else if (run == 1) begin
                rnd[1:0] = 2'd1;
            end
            wr_val[reg_len0 + k] = rnd;
        end
        for (int r = reg_src_base; r <= reg_len3; r++) begin
            host_write(r[3:0], wr_val[r]);
        end
        for (int r = reg_src_base; r <= reg_len3; r++) begin
            host_read(r[3:0], rd);
            check_eq("cfg_readback", wr_val[r] & 32'h1fff, rd);
        end
        run_src = wr_val[reg_src_base][agu_addr_w-1:0];
        run_dst = wr_val[reg_dst_base][agu_addr_w-1:0];
        for (int k = 0; k < agu_lvl_n; k++) begin
            run_gap[k] = wr_val[reg_gap0 + k][agu_addr_w-1:0];
            run_len[k] = wr_val[reg_len0 + k][agu_addr_w-1:0];
        end
    endtask

    // element order of the loop nest with level 3 innermost
    task automatic build_model();
        logic [agu_addr_w-1:0] a;
        logic [agu_addr_w-1:0] d;
        int idx;
        idx = 0;
        exp_rd_q.delete();
        for (int i = 0; i < mem_words; i++) begin
            exp_mem[i] = mem[i];
        end
        for (int c0 = 0; c0 <= run_len[0]; c0++) begin
            for (int c1 = 0; c1 <= run_len[1]; c1++) begin
                for (int c2 = 0; c2 <= run_len[2]; c2++) begin
                    for (int c3 = 0; c3 <= run_len[3]; c3++) begin
                        a = run_src + c0 * run_gap[0] + c1 * run_gap[1]
                            + c2 * run_gap[2] + c3 * run_gap[3];
                        d = run_dst + idx;
                        exp_rd_q.push_back(a);
                        exp_mem[d] = exp_mem[a];
                        idx++;
                    end
                end
            end
        end
    endtask

    // memory slave with 0 to 3 cycles of ack delay
    always @(negedge clk) begin
        if (rst_n) begin
            if (hold_chk) begin
                check_eq("hold_adr", held_adr, m_adr);
                check_eq("hold_we", held_we, m_we);
                check_eq("hold_dat_w", held_dat, m_dat_w);
            end
            if (m_ack) begin
                m_ack   = 1'b0;
                pending = 1'b0;
            end else if (m_cyc && m_stb) begin
                if (!pending) begin
                    pending  = 1'b1;
                    bp_rnd   = $random(seed);
                    wait_cnt = bp_rnd[1:0];
                end
                if (wait_cnt == 0) begin
                    m_ack = 1'b1;
                    if (m_we) begin
                        mem[m_adr] = m_dat_w;
                        wr_cnt++;
                    end else begin
                        m_dat_r = mem[m_adr];
                        rd_q.push_back(m_adr);
                    end
                end else begin
                    wait_cnt--;
                end
            end
            // fields must not move while the request waits
            hold_chk = m_cyc && m_stb && !m_ack;
            held_adr = m_adr;
            held_we  = m_we;
            held_dat = m_dat_w;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= timeout_cycles) begin
            errors++;
            $display("DUT hang: the regression did not finish within %0d cycles",
                     timeout_cycles);
            report_totals();
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] rd;
        rst_n    = 1'b0;
        s_cyc    = 1'b0;
        s_stb    = 1'b0;
        s_we     = 1'b0;
        s_adr    = '0;
        s_dat_w  = '0;
        m_dat_r  = '0;
        m_ack    = 1'b0;
        pending  = 1'b0;
        hold_chk = 1'b0;
        wait_cnt = 0;
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = $random(seed);
        end
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_eq("reset_outputs", 32'd0, {s_ack, m_cyc, m_stb, m_we});
        host_read(reg_status, rd);
        check_eq("reset_status", 32'd0, rd);
        host_read(4'd12, rd);
        check_eq("unmapped_read", 32'd0, rd);

        for (int run = 0; run < n_runs; run++) begin
            configure_run(run);
            build_model();
            rd_q.delete();
            wr_cnt = 0;
            host_write(reg_ctrl, 32'd1);
            // busy set and the previous done cleared
            host_read(reg_status, rd);
            check_eq("status_after_start", 32'd1, rd);
            if (exp_rd_q.size() >= 8) begin
                host_write(reg_ctrl, 32'd1);
            end
            do begin
                host_read(reg_status, rd);
            end while (!rd[1]);
            check_eq("status_done", 32'd2, rd);
            // master bus released once the run is over
            check_eq("bus_idle", 32'd0, {m_cyc, m_stb, m_we});
            check_eq("read_count", exp_rd_q.size(), rd_q.size());
            check_eq("write_count", exp_rd_q.size(), wr_cnt);
            for (int i = 0; i < rd_q.size() && i < exp_rd_q.size(); i++) begin
                check_eq("read_addr", exp_rd_q[i], rd_q[i]);
            end
            for (int i = 0; i < mem_words; i++) begin
                check_eq("dest_data", exp_mem[i], mem[i]);
            end
        end

        report_totals();
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
hdl/agu_pkg.sv
hdl/agu_addr_gen.sv
hdl/agu_cfg_regs.sv
hdl/agu_dma_ctrl.sv
hdl/agu_top.sv
tb/tb_agu_top.sv
